/* design/ao_periph_pkg.sv */
/*
 * Always-on peripheral subsystem package
 * Bus types, address map, register offsets and interrupt vector width
 */
`default_nettype none

package ao_periph_pkg;

  typedef logic [31:0] reg_addr_t;
  typedef logic [31:0] reg_data_t;
  typedef logic [3:0]  reg_strb_t;
  typedef logic [14:0] fast_intr_vec_t;

  localparam int unsigned NUM_AO_PERIPH   = 3;
  localparam int unsigned AO_PERIPH_SEL_W = 2;
  localparam int unsigned PERIPH_OFFSET_W = 12;

  localparam logic [AO_PERIPH_SEL_W-1:0] SOC_CTRL_IDX  = 2'd0;
  localparam logic [AO_PERIPH_SEL_W-1:0] FAST_INTR_IDX = 2'd1;
  localparam logic [AO_PERIPH_SEL_W-1:0] TIMER_IDX     = 2'd2;

  // 4 KiB window per peripheral
  localparam reg_addr_t SOC_CTRL_BASE  = 32'h0000_0000;
  localparam reg_addr_t FAST_INTR_BASE = 32'h0000_1000;
  localparam reg_addr_t TIMER_BASE     = 32'h0000_2000;

  localparam logic [PERIPH_OFFSET_W-1:0] SOC_CTRL_EXIT_VALID_OFFSET   = 12'h000;
  localparam logic [PERIPH_OFFSET_W-1:0] SOC_CTRL_EXIT_VALUE_OFFSET   = 12'h004;
  localparam logic [PERIPH_OFFSET_W-1:0] SOC_CTRL_BOOT_SELECT_OFFSET  = 12'h008;
  localparam logic [PERIPH_OFFSET_W-1:0] SOC_CTRL_USE_SPIMEMIO_OFFSET = 12'h00C;

  localparam logic [PERIPH_OFFSET_W-1:0] FAST_INTR_PENDING_OFFSET = 12'h000;
  localparam logic [PERIPH_OFFSET_W-1:0] FAST_INTR_ENABLE_OFFSET  = 12'h004;

  localparam logic [PERIPH_OFFSET_W-1:0] TIMER_CTRL_OFFSET        = 12'h000;
  localparam logic [PERIPH_OFFSET_W-1:0] TIMER_COUNT_OFFSET       = 12'h004;
  localparam logic [PERIPH_OFFSET_W-1:0] TIMER_CMP0_OFFSET        = 12'h008;
  localparam logic [PERIPH_OFFSET_W-1:0] TIMER_CMP1_OFFSET        = 12'h00C;
  localparam logic [PERIPH_OFFSET_W-1:0] TIMER_INTR_STATUS_OFFSET = 12'h010;

  // Byte enables expanded to a bit mask
  function automatic reg_data_t wstrb_mask(input reg_strb_t strb);
    reg_data_t mask;
    for (int i = 0; i < 4; i++) begin
      mask[8*i +: 8] = {8{strb[i]}};
    end
    return mask;
  endfunction

endpackage : ao_periph_pkg

`default_nettype wire

/* design/obi_reg_bridge.sv */
/*
 * OBI slave to register bus bridge
 * Grants every request at once, returns rvalid one cycle later
 */
`timescale 1ns/100ps
`default_nettype none

module obi_reg_bridge
  import ao_periph_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      arst_n_i,
  input  wire logic      obi_req_i,
  input  wire reg_addr_t obi_addr_i,
  input  wire logic      obi_we_i,
  input  wire reg_strb_t obi_be_i,
  input  wire reg_data_t obi_wdata_i,
  output logic           obi_gnt_o,
  output logic           obi_rvalid_o,
  output reg_data_t      obi_rdata_o,
  output logic           obi_err_o,
  output logic           reg_valid_o,
  output reg_addr_t      reg_addr_o,
  output logic           reg_write_o,
  output reg_strb_t      reg_wstrb_o,
  output reg_data_t      reg_wdata_o,
  input  wire reg_data_t reg_rdata_i,
  input  wire logic      reg_error_i
);

  logic      rvalid_q;
  logic      err_q;
  reg_data_t rdata_q;

  // Register bus never stalls
  assign obi_gnt_o   = obi_req_i;
  assign reg_valid_o = obi_req_i;
  assign reg_addr_o  = obi_addr_i;
  assign reg_write_o = obi_we_i;
  assign reg_wstrb_o = obi_be_i;
  assign reg_wdata_o = obi_wdata_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= obi_req_i;
      err_q    <= obi_req_i & reg_error_i;
    end
  end

  // Writes answer with zero data
  always_ff @(posedge clk_i) begin
    if (obi_req_i) begin
      rdata_q <= obi_we_i ? '0 : reg_rdata_i;
    end
  end

  assign obi_rvalid_o = rvalid_q;
  assign obi_rdata_o  = rdata_q;
  assign obi_err_o    = err_q;

endmodule : obi_reg_bridge

`default_nettype wire

/* design/ao_reg_xbar.sv */
/*
 * Address decoder and register bus demultiplexer
 * Steers each access to one peripheral, flags unmapped addresses
 */
`timescale 1ns/100ps
`default_nettype none

module ao_reg_xbar
  import ao_periph_pkg::*;
(
  input  wire logic                  reg_valid_i,
  input  wire reg_addr_t             reg_addr_i,
  input  wire logic                  reg_write_i,
  input  wire reg_strb_t             reg_wstrb_i,
  input  wire reg_data_t             reg_wdata_i,
  output reg_data_t                  reg_rdata_o,
  output logic                       reg_error_o,
  output logic                       soc_ctrl_valid_o,
  output logic                       fast_intr_valid_o,
  output logic                       timer_valid_o,
  output logic [PERIPH_OFFSET_W-1:0] periph_offset_o,
  output logic                       periph_write_o,
  output reg_strb_t                  periph_wstrb_o,
  output reg_data_t                  periph_wdata_o,
  input  wire reg_data_t             soc_ctrl_rdata_i,
  input  wire reg_data_t             fast_intr_rdata_i,
  input  wire reg_data_t             timer_rdata_i
);

  localparam int unsigned PAGE_W = 32 - PERIPH_OFFSET_W;

  logic [PAGE_W-1:0]          page;
  logic [AO_PERIPH_SEL_W-1:0] sel;
  logic                       hit;
  reg_data_t                  periph_rdata [NUM_AO_PERIPH];

  assign page = reg_addr_i[31:PERIPH_OFFSET_W];

  always_comb begin
    hit = 1'b1;
    sel = SOC_CTRL_IDX;
    if (page == SOC_CTRL_BASE[31:PERIPH_OFFSET_W]) begin
      sel = SOC_CTRL_IDX;
    end else if (page == FAST_INTR_BASE[31:PERIPH_OFFSET_W]) begin
      sel = FAST_INTR_IDX;
    end else if (page == TIMER_BASE[31:PERIPH_OFFSET_W]) begin
      sel = TIMER_IDX;
    end else begin
      hit = 1'b0;
    end
  end

  assign soc_ctrl_valid_o  = reg_valid_i & hit & (sel == SOC_CTRL_IDX);
  assign fast_intr_valid_o = reg_valid_i & hit & (sel == FAST_INTR_IDX);
  assign timer_valid_o     = reg_valid_i & hit & (sel == TIMER_IDX);

  // Request payload is shared, only the valids differ
  assign periph_offset_o = reg_addr_i[PERIPH_OFFSET_W-1:0];
  assign periph_write_o  = reg_write_i;
  assign periph_wstrb_o  = reg_wstrb_i;
  assign periph_wdata_o  = reg_wdata_i;

  assign periph_rdata[SOC_CTRL_IDX]  = soc_ctrl_rdata_i;
  assign periph_rdata[FAST_INTR_IDX] = fast_intr_rdata_i;
  assign periph_rdata[TIMER_IDX]     = timer_rdata_i;

  assign reg_rdata_o = hit ? periph_rdata[sel] : '0;
  assign reg_error_o = reg_valid_i & ~hit;

endmodule : ao_reg_xbar

`default_nettype wire

/* design/soc_ctrl.sv */
/*
 * SoC control registers
 * Exit value and strobe, boot select readback, flash memory-mapped select
 */
`timescale 1ns/100ps
`default_nettype none

module soc_ctrl
  import ao_periph_pkg::*;
(
  input  wire logic                       clk_i,
  input  wire logic                       arst_n_i,
  input  wire logic                       reg_valid_i,
  input  wire logic [PERIPH_OFFSET_W-1:0] reg_offset_i,
  input  wire logic                       reg_write_i,
  input  wire reg_strb_t                  reg_wstrb_i,
  input  wire reg_data_t                  reg_wdata_i,
  output reg_data_t                       reg_rdata_o,
  input  wire logic                       boot_select_i,
  input  wire logic                       execute_from_flash_i,
  output logic                            use_spimemio_o,
  output logic                            exit_valid_o,
  output reg_data_t                       exit_value_o
);

  reg_data_t mask;
  logic      wr_en;
  logic      exit_valid_q;
  logic      use_spimemio_q;
  reg_data_t exit_value_q;

  assign mask  = wstrb_mask(reg_wstrb_i);
  assign wr_en = reg_valid_i & reg_write_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exit_valid_q   <= 1'b0;
      exit_value_q   <= '0;
      use_spimemio_q <= 1'b0;
    end else if (wr_en) begin
      case (reg_offset_i)
        SOC_CTRL_EXIT_VALID_OFFSET: begin
          if (reg_wstrb_i[0]) exit_valid_q <= reg_wdata_i[0];
        end
        SOC_CTRL_EXIT_VALUE_OFFSET: begin
          exit_value_q <= (exit_value_q & ~mask) | (reg_wdata_i & mask);
        end
        SOC_CTRL_USE_SPIMEMIO_OFFSET: begin
          if (reg_wstrb_i[0]) use_spimemio_q <= reg_wdata_i[0];
        end
        default: ;
      endcase
    end
  end

  always_comb begin
    case (reg_offset_i)
      SOC_CTRL_EXIT_VALID_OFFSET:   reg_rdata_o = {31'b0, exit_valid_q};
      SOC_CTRL_EXIT_VALUE_OFFSET:   reg_rdata_o = exit_value_q;
      SOC_CTRL_BOOT_SELECT_OFFSET:  reg_rdata_o = {30'b0, execute_from_flash_i, boot_select_i};
      SOC_CTRL_USE_SPIMEMIO_OFFSET: reg_rdata_o = {31'b0, use_spimemio_q};
      default:                      reg_rdata_o = '0;
    endcase
  end

  assign exit_valid_o   = exit_valid_q;
  assign exit_value_o   = exit_value_q;
  assign use_spimemio_o = use_spimemio_q;

endmodule : soc_ctrl

`default_nettype wire

/* design/fast_intr_ctrl.sv */
/*
 * Fast interrupt controller
 * Pending bits with write-one-to-clear, masked by an enable register
 */
`timescale 1ns/100ps
`default_nettype none

module fast_intr_ctrl
  import ao_periph_pkg::*;
(
  input  wire logic                       clk_i,
  input  wire logic                       arst_n_i,
  input  wire logic                       reg_valid_i,
  input  wire logic [PERIPH_OFFSET_W-1:0] reg_offset_i,
  input  wire logic                       reg_write_i,
  input  wire reg_strb_t                  reg_wstrb_i,
  input  wire reg_data_t                  reg_wdata_i,
  output reg_data_t                       reg_rdata_o,
  input  wire fast_intr_vec_t             fast_intr_i,
  output fast_intr_vec_t                  fast_intr_o
);

  reg_data_t      wr_bits;
  reg_data_t      mask;
  fast_intr_vec_t clr;
  fast_intr_vec_t pending_q;
  fast_intr_vec_t enable_q;
  logic           wr_en;

  assign mask    = wstrb_mask(reg_wstrb_i);
  assign wr_bits = reg_wdata_i & mask;
  assign wr_en   = reg_valid_i & reg_write_i;
  assign clr     = (wr_en && reg_offset_i == FAST_INTR_PENDING_OFFSET) ? wr_bits[14:0] : '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_q <= '0;
      enable_q  <= '0;
    end else begin
      // A live input wins over a clear
      pending_q <= (pending_q & ~clr) | fast_intr_i;
      if (wr_en && reg_offset_i == FAST_INTR_ENABLE_OFFSET) begin
        enable_q <= (enable_q & ~mask[14:0]) | wr_bits[14:0];
      end
    end
  end

  always_comb begin
    case (reg_offset_i)
      FAST_INTR_PENDING_OFFSET: reg_rdata_o = {17'b0, pending_q};
      FAST_INTR_ENABLE_OFFSET:  reg_rdata_o = {17'b0, enable_q};
      default:                  reg_rdata_o = '0;
    endcase
  end

  assign fast_intr_o = pending_q & enable_q;

endmodule : fast_intr_ctrl

`default_nettype wire

/* design/ao_timer.sv */
/*
 * Always-on machine timer
 * 32-bit counter, two compare channels, sticky interrupt status
 */
`timescale 1ns/100ps
`default_nettype none

module ao_timer
  import ao_periph_pkg::*;
(
  input  wire logic                       clk_i,
  input  wire logic                       arst_n_i,
  input  wire logic                       reg_valid_i,
  input  wire logic [PERIPH_OFFSET_W-1:0] reg_offset_i,
  input  wire logic                       reg_write_i,
  input  wire reg_strb_t                  reg_wstrb_i,
  input  wire reg_data_t                  reg_wdata_i,
  output reg_data_t                       reg_rdata_o,
  output logic                            timer_0_intr_o,
  output logic                            timer_1_intr_o
);

  reg_data_t  mask;
  reg_data_t  wr_bits;
  logic       wr_en;
  logic       enable_q;
  reg_data_t  count_q;
  reg_data_t  cmp0_q;
  reg_data_t  cmp1_q;
  logic [1:0] status_q;
  logic [1:0] hit;
  logic [1:0] clr;

  assign mask    = wstrb_mask(reg_wstrb_i);
  assign wr_bits = reg_wdata_i & mask;
  assign wr_en   = reg_valid_i & reg_write_i;

  // Compare only while running
  assign hit[0] = enable_q & (count_q == cmp0_q);
  assign hit[1] = enable_q & (count_q == cmp1_q);
  assign clr    = (wr_en && reg_offset_i == TIMER_INTR_STATUS_OFFSET) ? wr_bits[1:0] : 2'b00;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      enable_q <= 1'b0;
      count_q  <= '0;
      cmp0_q   <= '0;
      cmp1_q   <= '0;
      status_q <= 2'b00;
    end else begin
      status_q <= (status_q & ~clr) | hit;
      if (wr_en && reg_offset_i == TIMER_COUNT_OFFSET) begin
        count_q <= (count_q & ~mask) | wr_bits;
      end else if (enable_q) begin
        count_q <= count_q + 32'd1;
      end
      if (wr_en && reg_offset_i == TIMER_CTRL_OFFSET && reg_wstrb_i[0]) begin
        enable_q <= reg_wdata_i[0];
      end
      if (wr_en && reg_offset_i == TIMER_CMP0_OFFSET) begin
        cmp0_q <= (cmp0_q & ~mask) | wr_bits;
      end
      if (wr_en && reg_offset_i == TIMER_CMP1_OFFSET) begin
        cmp1_q <= (cmp1_q & ~mask) | wr_bits;
      end
    end
  end

  always_comb begin
    case (reg_offset_i)
      TIMER_CTRL_OFFSET:        reg_rdata_o = {31'b0, enable_q};
      TIMER_COUNT_OFFSET:       reg_rdata_o = count_q;
      TIMER_CMP0_OFFSET:        reg_rdata_o = cmp0_q;
      TIMER_CMP1_OFFSET:        reg_rdata_o = cmp1_q;
      TIMER_INTR_STATUS_OFFSET: reg_rdata_o = {30'b0, status_q};
      default:                  reg_rdata_o = '0;
    endcase
  end

  assign timer_0_intr_o = status_q[0];
  assign timer_1_intr_o = status_q[1];

endmodule : ao_timer

`default_nettype wire

/* design/ao_peripheral_subsystem.sv */
/*
 * Always-on peripheral subsystem top
 * OBI bridge, register crossbar, SoC control, fast interrupts and timer
 */
`timescale 1ns/100ps
`default_nettype none

module ao_peripheral_subsystem
  import ao_periph_pkg::*;
(
  input  wire logic           clk_i,
  input  wire logic           arst_n_i,
  input  wire logic           obi_req_i,
  input  wire reg_addr_t      obi_addr_i,
  input  wire logic           obi_we_i,
  input  wire reg_strb_t      obi_be_i,
  input  wire reg_data_t      obi_wdata_i,
  output logic                obi_gnt_o,
  output logic                obi_rvalid_o,
  output reg_data_t           obi_rdata_o,
  output logic                obi_err_o,
  input  wire logic           boot_select_i,
  input  wire logic           execute_from_flash_i,
  output logic                use_spimemio_o,
  output logic                exit_valid_o,
  output reg_data_t           exit_value_o,
  input  wire fast_intr_vec_t fast_intr_i,
  output fast_intr_vec_t      fast_intr_o,
  output logic                timer_0_intr_o,
  output logic                timer_1_intr_o
);

  logic                       reg_valid;
  reg_addr_t                  reg_addr;
  logic                       reg_write;
  reg_strb_t                  reg_wstrb;
  reg_data_t                  reg_wdata;
  reg_data_t                  reg_rdata;
  logic                       reg_error;

  logic                       soc_ctrl_valid;
  logic                       fast_intr_valid;
  logic                       timer_valid;
  logic [PERIPH_OFFSET_W-1:0] periph_offset;
  logic                       periph_write;
  reg_strb_t                  periph_wstrb;
  reg_data_t                  periph_wdata;
  reg_data_t                  soc_ctrl_rdata;
  reg_data_t                  fast_intr_rdata;
  reg_data_t                  timer_rdata;

  obi_reg_bridge obi_reg_bridge_i (
    .clk_i,
    .arst_n_i,
    .obi_req_i,
    .obi_addr_i,
    .obi_we_i,
    .obi_be_i,
    .obi_wdata_i,
    .obi_gnt_o,
    .obi_rvalid_o,
    .obi_rdata_o,
    .obi_err_o,
    .reg_valid_o (reg_valid),
    .reg_addr_o  (reg_addr),
    .reg_write_o (reg_write),
    .reg_wstrb_o (reg_wstrb),
    .reg_wdata_o (reg_wdata),
    .reg_rdata_i (reg_rdata),
    .reg_error_i (reg_error)
  );

  ao_reg_xbar ao_reg_xbar_i (
    .reg_valid_i       (reg_valid),
    .reg_addr_i        (reg_addr),
    .reg_write_i       (reg_write),
    .reg_wstrb_i       (reg_wstrb),
    .reg_wdata_i       (reg_wdata),
    .reg_rdata_o       (reg_rdata),
    .reg_error_o       (reg_error),
    .soc_ctrl_valid_o  (soc_ctrl_valid),
    .fast_intr_valid_o (fast_intr_valid),
    .timer_valid_o     (timer_valid),
    .periph_offset_o   (periph_offset),
    .periph_write_o    (periph_write),
    .periph_wstrb_o    (periph_wstrb),
    .periph_wdata_o    (periph_wdata),
    .soc_ctrl_rdata_i  (soc_ctrl_rdata),
    .fast_intr_rdata_i (fast_intr_rdata),
    .timer_rdata_i     (timer_rdata)
  );

  soc_ctrl soc_ctrl_i (
    .clk_i,
    .arst_n_i,
    .reg_valid_i  (soc_ctrl_valid),
    .reg_offset_i (periph_offset),
    .reg_write_i  (periph_write),
    .reg_wstrb_i  (periph_wstrb),
    .reg_wdata_i  (periph_wdata),
    .reg_rdata_o  (soc_ctrl_rdata),
    .boot_select_i,
    .execute_from_flash_i,
    .use_spimemio_o,
    .exit_valid_o,
    .exit_value_o
  );

  fast_intr_ctrl fast_intr_ctrl_i (
    .clk_i,
    .arst_n_i,
    .reg_valid_i  (fast_intr_valid),
    .reg_offset_i (periph_offset),
    .reg_write_i  (periph_write),
    .reg_wstrb_i  (periph_wstrb),
    .reg_wdata_i  (periph_wdata),
    .reg_rdata_o  (fast_intr_rdata),
    .fast_intr_i,
    .fast_intr_o
  );

  ao_timer ao_timer_i (
    .clk_i,
    .arst_n_i,
    .reg_valid_i  (timer_valid),
    .reg_offset_i (periph_offset),
    .reg_write_i  (periph_write),
    .reg_wstrb_i  (periph_wstrb),
    .reg_wdata_i  (periph_wdata),
    .reg_rdata_o  (timer_rdata),
    .timer_0_intr_o,
    .timer_1_intr_o
  );

endmodule : ao_peripheral_subsystem

`default_nettype wire

/* verif/ao_peripheral_subsystem_tb.sv */
/*
 * Always-on peripheral subsystem testbench
 * Table-driven OBI accesses to SoC control, fast interrupts and timer
 */
`timescale 1ns/100ps
`default_nettype none

module ao_peripheral_subsystem_tb
  import ao_periph_pkg::*;
();

  localparam int unsigned TIMEOUT_CYCLES = 1000;
  localparam reg_addr_t   UNMAPPED_ADDR  = 32'h0000_3000;
  localparam reg_data_t   CMP0_VAL       = 32'd20;
  localparam reg_data_t   CMP1_VAL       = 32'd60;

  logic           clk_i;
  logic           arst_n_i;
  logic           obi_req_i;
  reg_addr_t      obi_addr_i;
  logic           obi_we_i;
  reg_strb_t      obi_be_i;
  reg_data_t      obi_wdata_i;
  logic           obi_gnt_o;
  logic           obi_rvalid_o;
  reg_data_t      obi_rdata_o;
  logic           obi_err_o;
  logic           boot_select_i;
  logic           execute_from_flash_i;
  logic           use_spimemio_o;
  logic           exit_valid_o;
  reg_data_t      exit_value_o;
  fast_intr_vec_t fast_intr_i;
  fast_intr_vec_t fast_intr_o;
  logic           timer_0_intr_o;
  logic           timer_1_intr_o;

  int unsigned error_cnt;
  int unsigned timeout_cnt;

  // Access table, one entry per index
  string     tbl_name[$];
  logic      tbl_we[$];
  reg_addr_t tbl_addr[$];
  reg_strb_t tbl_be[$];
  reg_data_t tbl_wdata[$];
  reg_data_t tbl_rdata[$];
  logic      tbl_err[$];

  ao_peripheral_subsystem dut0 (.*);

  always #50 clk_i = ~clk_i;

  task automatic check_data(input string name, input reg_data_t exp, input reg_data_t act);
    if (act !== exp) begin
      error_cnt++;
      $display("Error: %s expected 0x%08h actual 0x%08h", name, exp, act);
    end
  endtask

  task automatic check_intr(input string name, input fast_intr_vec_t exp,
                            input fast_intr_vec_t act);
    if (act !== exp) begin
      error_cnt++;
      $display("Error: %s expected 0x%04h actual 0x%04h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      error_cnt++;
      $display("Error: %s expected %b actual %b", name, exp, act);
    end
  endtask

  // Only the enabled bytes take the new value
  function automatic reg_data_t merge_bytes(input reg_data_t old_word, input reg_data_t new_word,
                                            input reg_strb_t be);
    reg_data_t res;
    res = old_word;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) res[8*i +: 8] = new_word[8*i +: 8];
    end
    return res;
  endfunction

  task automatic obi_access(input string name, input logic we, input reg_addr_t addr,
                            input reg_strb_t be, input reg_data_t wdata,
                            output reg_data_t rdata, output logic err);
    int unsigned cycles;
    rdata = '0;
    err   = 1'b0;
    @(posedge clk_i);
    obi_req_i   <= 1'b1;
    obi_we_i    <= we;
    obi_addr_i  <= addr;
    obi_be_i    <= be;
    obi_wdata_i <= wdata;
    cycles = 0;
    @(negedge clk_i);
    while (!obi_gnt_o && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!obi_gnt_o) begin
      timeout_cnt++;
      $display("%s: request was not granted within %0d cycles", name, TIMEOUT_CYCLES);
      @(posedge clk_i);
      obi_req_i <= 1'b0;
    end else begin
      check_data({name, " grant latency"}, 32'd0, cycles);
      // No response yet in the request cycle
      check_bit({name, " early rvalid"}, 1'b0, obi_rvalid_o);
      // Grant edge
      @(posedge clk_i);
      obi_req_i <= 1'b0;
      cycles = 1;
      @(negedge clk_i);
      while (!obi_rvalid_o && cycles < TIMEOUT_CYCLES) begin
        @(negedge clk_i);
        cycles++;
      end
      if (!obi_rvalid_o) begin
        timeout_cnt++;
        $display("%s: no rvalid within %0d cycles of the grant", name, TIMEOUT_CYCLES);
      end else begin
        check_data({name, " rvalid latency"}, 32'd1, cycles);
        rdata = obi_rdata_o;
        err   = obi_err_o;
      end
    end
  endtask

  task automatic add_access(input string name, input logic we, input reg_addr_t addr,
                            input reg_strb_t be, input reg_data_t wdata,
                            input reg_data_t exp_rdata, input logic exp_err);
    tbl_name.push_back(name);
    tbl_we.push_back(we);
    tbl_addr.push_back(addr);
    tbl_be.push_back(be);
    tbl_wdata.push_back(wdata);
    tbl_rdata.push_back(exp_rdata);
    tbl_err.push_back(exp_err);
  endtask

  task automatic run_table();
    reg_data_t rdata;
    logic      err;
    for (int i = 0; i < tbl_name.size(); i++) begin
      obi_access(tbl_name[i], tbl_we[i], tbl_addr[i], tbl_be[i], tbl_wdata[i], rdata, err);
      check_data(tbl_name[i], tbl_rdata[i], rdata);
      check_bit({tbl_name[i], " error"}, tbl_err[i], err);
    end
    tbl_name.delete();
    tbl_we.delete();
    tbl_addr.delete();
    tbl_be.delete();
    tbl_wdata.delete();
    tbl_rdata.delete();
    tbl_err.delete();
  endtask

  initial begin
    reg_data_t      word_a;
    reg_data_t      word_b;
    reg_data_t      exit_exp;
    reg_data_t      rdata;
    reg_data_t      count_a;
    logic           err;
    fast_intr_vec_t pattern;
    fast_intr_vec_t enable;
    fast_intr_vec_t clear;
    int unsigned    cycles;
    int unsigned    seed_val;

    seed_val             = $urandom(32'h5189);
    error_cnt            = 0;
    timeout_cnt          = 0;
    clk_i                = 1'b0;
    arst_n_i             = 1'b0;
    obi_req_i            = 1'b0;
    obi_addr_i           = '0;
    obi_we_i             = 1'b0;
    obi_be_i             = '0;
    obi_wdata_i          = '0;
    boot_select_i        = 1'b0;
    execute_from_flash_i = 1'b0;
    fast_intr_i          = '0;
    repeat (2) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(negedge clk_i);

    check_bit("reset obi_gnt_o", 1'b0, obi_gnt_o);
    check_bit("reset obi_rvalid_o", 1'b0, obi_rvalid_o);
    check_bit("reset exit_valid_o", 1'b0, exit_valid_o);
    check_bit("reset use_spimemio_o", 1'b0, use_spimemio_o);
    check_bit("reset timer_0_intr_o", 1'b0, timer_0_intr_o);
    check_bit("reset timer_1_intr_o", 1'b0, timer_1_intr_o);
    check_intr("reset fast_intr_o", '0, fast_intr_o);
    add_access("reset COUNT", 1'b0, TIMER_BASE + TIMER_COUNT_OFFSET, 4'hF, '0, '0, 1'b0);
    add_access("reset CMP0", 1'b0, TIMER_BASE + TIMER_CMP0_OFFSET, 4'hF, '0, '0, 1'b0);
    add_access("reset CMP1", 1'b0, TIMER_BASE + TIMER_CMP1_OFFSET, 4'hF, '0, '0, 1'b0);
    run_table();

    // SoC control round trip
    word_a   = $urandom();
    word_b   = $urandom();
    exit_exp = merge_bytes(word_a, word_b, 4'b0101);
    add_access("exit value write", 1'b1, SOC_CTRL_BASE + SOC_CTRL_EXIT_VALUE_OFFSET, 4'hF,
               word_a, '0, 1'b0);
    add_access("exit value read", 1'b0, SOC_CTRL_BASE + SOC_CTRL_EXIT_VALUE_OFFSET, 4'hF,
               '0, word_a, 1'b0);
    add_access("exit value partial write", 1'b1, SOC_CTRL_BASE + SOC_CTRL_EXIT_VALUE_OFFSET,
               4'b0101, word_b, '0, 1'b0);
    add_access("exit value partial read", 1'b0, SOC_CTRL_BASE + SOC_CTRL_EXIT_VALUE_OFFSET,
               4'hF, '0, exit_exp, 1'b0);
    add_access("exit valid write", 1'b1, SOC_CTRL_BASE + SOC_CTRL_EXIT_VALID_OFFSET, 4'h1,
               32'd1, '0, 1'b0);
    add_access("exit valid read", 1'b0, SOC_CTRL_BASE + SOC_CTRL_EXIT_VALID_OFFSET, 4'hF,
               '0, 32'd1, 1'b0);
    add_access("spimemio set", 1'b1, SOC_CTRL_BASE + SOC_CTRL_USE_SPIMEMIO_OFFSET, 4'h1,
               32'd1, '0, 1'b0);
    add_access("spimemio read", 1'b0, SOC_CTRL_BASE + SOC_CTRL_USE_SPIMEMIO_OFFSET, 4'hF,
               '0, 32'd1, 1'b0);
    run_table();
    check_bit("exit_valid_o", 1'b1, exit_valid_o);
    check_data("exit_value_o", exit_exp, exit_value_o);
    check_bit("use_spimemio_o set", 1'b1, use_spimemio_o);
    add_access("spimemio clear", 1'b1, SOC_CTRL_BASE + SOC_CTRL_USE_SPIMEMIO_OFFSET, 4'h1,
               32'd0, '0, 1'b0);
    run_table();
    check_bit("use_spimemio_o clear", 1'b0, use_spimemio_o);

    // All four boot input combinations
    for (int i = 0; i < 4; i++) begin
      @(posedge clk_i);
      boot_select_i        <= i[0];
      execute_from_flash_i <= i[1];
      add_access($sformatf("boot select %0d", i), 1'b0,
                 SOC_CTRL_BASE + SOC_CTRL_BOOT_SELECT_OFFSET, 4'hF, '0, reg_data_t'(i), 1'b0);
      run_table();
    end

    add_access("unmapped read", 1'b0, UNMAPPED_ADDR, 4'hF, '0, '0, 1'b1);
    add_access("unmapped write", 1'b1, UNMAPPED_ADDR + 32'd4, 4'hF, $urandom(), '0, 1'b1);
    add_access("far unmapped read", 1'b0, 32'h8000_0000, 4'hF, '0, '0, 1'b1);
    add_access("unknown timer offset", 1'b0, TIMER_BASE + 32'h100, 4'hF, '0, '0, 1'b0);
    run_table();
    check_data("exit_value_o after unmapped", exit_exp, exit_value_o);

    // Fast interrupts
    pattern = fast_intr_vec_t'($urandom()) | 15'h0001;
    enable  = fast_intr_vec_t'($urandom());
    clear   = fast_intr_vec_t'($urandom()) & pattern;
    add_access("fast intr enable write", 1'b1, FAST_INTR_BASE + FAST_INTR_ENABLE_OFFSET, 4'hF,
               {17'b0, enable}, '0, 1'b0);
    add_access("fast intr enable read", 1'b0, FAST_INTR_BASE + FAST_INTR_ENABLE_OFFSET, 4'hF,
               '0, {17'b0, enable}, 1'b0);
    run_table();
    @(posedge clk_i);
    fast_intr_i <= pattern;
    @(posedge clk_i);
    fast_intr_i <= '0;
    @(negedge clk_i);
    check_intr("fast_intr_o masked", pattern & enable, fast_intr_o);
    add_access("pending read", 1'b0, FAST_INTR_BASE + FAST_INTR_PENDING_OFFSET, 4'hF,
               '0, {17'b0, pattern}, 1'b0);
    add_access("pending clear", 1'b1, FAST_INTR_BASE + FAST_INTR_PENDING_OFFSET, 4'hF,
               {17'b0, clear}, '0, 1'b0);
    add_access("pending after clear", 1'b0, FAST_INTR_BASE + FAST_INTR_PENDING_OFFSET, 4'hF,
               '0, {17'b0, pattern & ~clear}, 1'b0);
    run_table();
    check_intr("fast_intr_o after clear", pattern & ~clear & enable, fast_intr_o);

    // Timer
    add_access("cmp0 write", 1'b1, TIMER_BASE + TIMER_CMP0_OFFSET, 4'hF, CMP0_VAL, '0, 1'b0);
    add_access("cmp1 write", 1'b1, TIMER_BASE + TIMER_CMP1_OFFSET, 4'hF, CMP1_VAL, '0, 1'b0);
    add_access("cmp1 read", 1'b0, TIMER_BASE + TIMER_CMP1_OFFSET, 4'hF, '0, CMP1_VAL, 1'b0);
    add_access("timer enable", 1'b1, TIMER_BASE + TIMER_CTRL_OFFSET, 4'hF, 32'd1, '0, 1'b0);
    run_table();
    cycles = 0;
    while (!timer_0_intr_o && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!timer_0_intr_o) begin
      timeout_cnt++;
      $display("timer_0_intr_o did not rise within %0d cycles", TIMEOUT_CYCLES);
    end
    check_bit("timer_1_intr_o when timer_0 rises", 1'b0, timer_1_intr_o);
    cycles = 0;
    while (!timer_1_intr_o && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!timer_1_intr_o) begin
      timeout_cnt++;
      $display("timer_1_intr_o did not rise within %0d cycles", TIMEOUT_CYCLES);
    end
    obi_access("count after cmp1", 1'b0, TIMER_BASE + TIMER_COUNT_OFFSET, 4'hF, '0, rdata, err);
    check_bit("count at least cmp1", 1'b1, rdata >= CMP1_VAL);
    add_access("status clear", 1'b1, TIMER_BASE + TIMER_INTR_STATUS_OFFSET, 4'hF, 32'd3,
               '0, 1'b0);
    add_access("status read", 1'b0, TIMER_BASE + TIMER_INTR_STATUS_OFFSET, 4'hF, '0, '0, 1'b0);
    add_access("timer disable", 1'b1, TIMER_BASE + TIMER_CTRL_OFFSET, 4'hF, 32'd0, '0, 1'b0);
    run_table();
    check_bit("timer_0_intr_o cleared", 1'b0, timer_0_intr_o);
    check_bit("timer_1_intr_o cleared", 1'b0, timer_1_intr_o);
    obi_access("frozen count 0", 1'b0, TIMER_BASE + TIMER_COUNT_OFFSET, 4'hF, '0, count_a, err);
    obi_access("frozen count 1", 1'b0, TIMER_BASE + TIMER_COUNT_OFFSET, 4'hF, '0, rdata, err);
    check_data("count frozen", count_a, rdata);
    check_bit("frozen count error", 1'b0, err);

    $display("Errors: %0d, timeouts: %0d", error_cnt, timeout_cnt);
    if (error_cnt == 0 && timeout_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule : ao_peripheral_subsystem_tb

`default_nettype wire

/* verilog.f */
design/ao_periph_pkg.sv
design/obi_reg_bridge.sv
design/ao_reg_xbar.sv
design/soc_ctrl.sv
design/fast_intr_ctrl.sv
design/ao_timer.sv
design/ao_peripheral_subsystem.sv
verif/ao_peripheral_subsystem_tb.sv
